// File: pcs_cfg.svh
`ifndef PCS_CFG_SVH
`define PCS_CFG_SVH

// pma word, sync header and full block widths
`define PCS_DATA_W 64
`define PCS_HEAD_W 2
`define PCS_BLOCK_W 66

// descrambler shift state, 1 + x^39 + x^58
`define PCS_SCR_W 58

// blocks per sync header window
`define PCS_SYNC_WIN 64
// bad headers per window that drop lock
`define PCS_BAD_MAX 16
`define PCS_BAD_W 5

`endif

// File: pcs_pkg.sv
`include "pcs_cfg.svh"

package pcs_pkg;

	// block lock states
	typedef enum logic [1:0] {
		ST_HUNT = 2'd0,
		// one block ignored after a slip
		ST_SLIP_WAIT = 2'd1,
		ST_LOCKED = 2'd2
	} sync_state_t;

	// valid sync header codes
	localparam logic [`PCS_HEAD_W-1:0] SH_DATA = 2'b01;
	localparam logic [`PCS_HEAD_W-1:0] SH_CTRL = 2'b10;

	// 00 and 11 never appear on a good link
	function automatic logic head_bad(input logic [`PCS_HEAD_W-1:0] head);
		logic bad;
		bad = (head != SH_DATA) && (head != SH_CTRL);
		return bad;
	endfunction

endpackage

// File: gearbox_if.sv
`timescale 1ns/1ps
`include "pcs_cfg.svh"

// gearbox output block and the slip request back to it
interface gearbox_if;

	// one cycle per assembled block
	logic blk_v;
	logic [`PCS_HEAD_W-1:0] head;
	logic [`PCS_DATA_W-1:0] data;
	// drop one stream bit, only with blk_v
	logic slip;

	modport gbx (
		output blk_v,
		output head,
		output data,
		input slip
	);

	modport sync (
		input blk_v,
		input head,
		output slip
	);

endinterface

// File: gearbox_rx.sv
`timescale 1ns/1ps
`include "pcs_cfg.svh"

module gearbox_rx (
	input logic clk,
	input logic nreset,
	// pma
	input logic lock_v_i,
	input logic [`PCS_DATA_W-1:0] data_i,
	// to block sync
	gearbox_if.gbx gb
);

// at most one bit short of a block is left over
localparam int RES_W = `PCS_BLOCK_W - 1;
localparam int STR_W = RES_W + `PCS_DATA_W;
localparam int CNT_W = $clog2(STR_W + 1);

localparam logic [CNT_W-1:0] DATA_N = CNT_W'(`PCS_DATA_W);
localparam logic [CNT_W-1:0] BLOCK_N = CNT_W'(`PCS_BLOCK_W);
localparam logic [CNT_W-1:0] RES_MAX = CNT_W'(RES_W);

// residue bits, oldest at bit 0, zero above cnt_q
logic [RES_W-1:0] res_q;
logic [CNT_W-1:0] cnt_q;
// slip from the last block, drop one bit this cycle
logic drop_q;

logic [STR_W-1:0] stream;
logic [STR_W-1:0] stream_dr;
logic [CNT_W-1:0] avail;
logic blk_v;
logic [STR_W-1:0] left;
logic [CNT_W-1:0] left_cnt;

// residue then new word, lsb first on the wire
assign stream = {{(STR_W-RES_W){1'b0}}, res_q}
	| ({{(STR_W-`PCS_DATA_W){1'b0}}, data_i} << cnt_q);

// pending slip removes the oldest unconsumed bit
assign stream_dr = drop_q ? (stream >> 1) : stream;
assign avail = cnt_q + DATA_N - {{(CNT_W-1){1'b0}}, drop_q};

// no block in the gap cycle, none while pma unlocked
assign blk_v = lock_v_i & (avail >= BLOCK_N);

// what is carried over into the next cycle
assign left = blk_v ? (stream_dr >> `PCS_BLOCK_W) : stream_dr;
assign left_cnt = blk_v ? (avail - BLOCK_N) : avail;

// header on bits 1:0, payload above
assign gb.blk_v = blk_v;
assign gb.head = stream_dr[`PCS_HEAD_W-1:0];
assign gb.data = stream_dr[`PCS_BLOCK_W-1:`PCS_HEAD_W];

always_ff @(posedge clk) begin
	if (!nreset) begin
		res_q <= '0;
		cnt_q <= '0;
		drop_q <= 1'b0;
	end else if (!lock_v_i) begin
		// restart alignment from the next locked word
		res_q <= '0;
		cnt_q <= '0;
		drop_q <= 1'b0;
	end else begin
		// upper bits of left are always zero here
		res_q <= left[RES_W-1:0];
		cnt_q <= left_cnt;
		drop_q <= gb.slip;
	end
end

// residue must fit the buffer
a_res_bound : assert property (
	@(posedge clk) disable iff (!nreset)
	cnt_q <= RES_MAX
);

endmodule

// File: sh_counter.sv
`timescale 1ns/1ps
`include "pcs_cfg.svh"

module sh_counter (
	input logic clk,
	input logic nreset,
	input logic count_v_i,
	input logic bad_v_i,
	input logic clear_i,
	output logic win_done_o,
	output logic [`PCS_BAD_W-1:0] bad_cnt_o
);

localparam int WIN_W = $clog2(`PCS_SYNC_WIN);
localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(`PCS_SYNC_WIN - 1);
localparam logic [`PCS_BAD_W-1:0] BAD_MAX = `PCS_BAD_W'(`PCS_BAD_MAX);

logic [WIN_W-1:0] blk_cnt_q;
logic [`PCS_BAD_W-1:0] bad_cnt_q;
logic win_done_q;
logic win_last;
logic bad_sat;

assign win_last = blk_cnt_q == WIN_LAST;
// stop counting bad headers at the threshold
assign bad_sat = bad_cnt_q >= BAD_MAX;

always_ff @(posedge clk) begin
	if (!nreset) begin
		blk_cnt_q <= '0;
		bad_cnt_q <= '0;
		win_done_q <= 1'b0;
	end else if (clear_i) begin
		blk_cnt_q <= '0;
		bad_cnt_q <= '0;
		win_done_q <= 1'b0;
	end else if (count_v_i) begin
		if (win_last) begin
			// window full, restart both
			blk_cnt_q <= '0;
			bad_cnt_q <= '0;
			win_done_q <= 1'b1;
		end else begin
			blk_cnt_q <= blk_cnt_q + 1'b1;
			if (bad_v_i && !bad_sat) begin
				bad_cnt_q <= bad_cnt_q + 1'b1;
			end
			win_done_q <= 1'b0;
		end
	end else begin
		win_done_q <= 1'b0;
	end
end

assign win_done_o = win_done_q;
assign bad_cnt_o = bad_cnt_q;

a_bad_bound : assert property (
	@(posedge clk) disable iff (!nreset)
	bad_cnt_q <= BAD_MAX
);

endmodule

// File: block_sync_fsm.sv
`timescale 1ns/1ps
`include "pcs_cfg.svh"

module block_sync_fsm import pcs_pkg::*; (
	input logic clk,
	input logic nreset,
	input logic lock_v_i,
	gearbox_if.sync gb,
	// from the header counter
	input logic win_done_i,
	input logic [`PCS_BAD_W-1:0] bad_cnt_i,
	// to the header counter
	output logic cnt_v_o,
	output logic bad_v_o,
	output logic clear_o,
	output logic block_lock_o
);

localparam logic [`PCS_BAD_W-1:0] BAD_LAST = `PCS_BAD_W'(`PCS_BAD_MAX - 1);

sync_state_t state_q;
sync_state_t state_next;
logic lock_q;
logic lock_next;
logic bad;
logic bad_last;
logic slip;
logic clear;

assign bad = head_bad(gb.head);
// count is one block behind, so add this block's bad header
assign bad_last = bad && (bad_cnt_i >= BAD_LAST);

always_comb begin
	state_next = state_q;
	lock_next = lock_q;
	slip = 1'b0;
	clear = 1'b0;
	case (state_q)
		ST_HUNT: begin
			// any bad header means wrong alignment
			if (gb.blk_v && bad) begin
				slip = 1'b1;
				state_next = ST_SLIP_WAIT;
			end else if (win_done_i) begin
				lock_next = 1'b1;
				state_next = ST_LOCKED;
			end
		end
		ST_SLIP_WAIT: begin
			// skip one block, restart the window
			if (gb.blk_v) begin
				clear = 1'b1;
				state_next = ST_HUNT;
			end
		end
		ST_LOCKED: begin
			if (gb.blk_v && bad_last) begin
				slip = 1'b1;
				lock_next = 1'b0;
				state_next = ST_SLIP_WAIT;
			end
		end
		default: begin
			state_next = ST_HUNT;
			lock_next = 1'b0;
		end
	endcase
	// pma lost, start over
	if (!lock_v_i) begin
		state_next = ST_HUNT;
		lock_next = 1'b0;
		slip = 1'b0;
		clear = 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (!nreset) begin
		state_q <= ST_HUNT;
		lock_q <= 1'b0;
	end else begin
		state_q <= state_next;
		lock_q <= lock_next;
	end
end

// the block after a slip is not counted
assign cnt_v_o = gb.blk_v && lock_v_i && (state_q != ST_SLIP_WAIT);
assign bad_v_o = cnt_v_o && bad;
assign clear_o = clear;
assign gb.slip = slip;
assign block_lock_o = lock_q;

// gearbox only honours a slip on a block cycle
a_slip_blk : assert property (
	@(posedge clk) disable iff (!nreset)
	gb.slip |-> gb.blk_v
);

endmodule

// File: descrambler.sv
`timescale 1ns/1ps
`include "pcs_cfg.svh"

module descrambler (
	input logic clk,
	input logic nreset,
	input logic blk_v_i,
	input logic block_lock_i,
	input logic [`PCS_HEAD_W-1:0] head_i,
	input logic [`PCS_DATA_W-1:0] data_i,
	output logic valid_o,
	output logic [`PCS_HEAD_W-1:0] head_o,
	output logic [`PCS_DATA_W-1:0] data_o
);

// taps for x^39 and x^58
localparam int TAP_A = 38;
localparam int TAP_B = `PCS_SCR_W - 1;

// last received scrambled bits, newest at bit 0
logic [`PCS_SCR_W-1:0] scr_q;
logic [`PCS_SCR_W-1:0] scr_next;
logic [`PCS_DATA_W-1:0] descr;
logic valid_q;
logic [`PCS_HEAD_W-1:0] head_q;
logic [`PCS_DATA_W-1:0] data_q;

// self-synchronizing, shift in the received bit, lsb first
always_comb begin
	scr_next = scr_q;
	for (int i = 0; i < `PCS_DATA_W; i++) begin
		descr[i] = data_i[i] ^ scr_next[TAP_A] ^ scr_next[TAP_B];
		scr_next = {scr_next[`PCS_SCR_W-2:0], data_i[i]};
	end
end

always_ff @(posedge clk) begin
	if (!nreset) begin
		scr_q <= '0;
		valid_q <= 1'b0;
		head_q <= '0;
		data_q <= '0;
	end else begin
		valid_q <= blk_v_i && block_lock_i;
		// state runs while hunting too, so it is full at lock
		if (blk_v_i) begin
			scr_q <= scr_next;
			head_q <= head_i;
			data_q <= descr;
		end
	end
end

assign valid_o = valid_q;
assign head_o = head_q;
assign data_o = data_q;

endmodule

// File: pcs_rx.sv
`timescale 1ns/1ps
`include "pcs_cfg.svh"

module pcs_rx (
	input logic clk,
	input logic nreset,
	// pma
	input logic lock_v_i,
	input logic [`PCS_DATA_W-1:0] data_i,
	// descrambled blocks
	output logic block_lock_o,
	output logic valid_o,
	output logic [`PCS_HEAD_W-1:0] head_o,
	output logic [`PCS_DATA_W-1:0] data_o
);

logic cnt_v;
logic bad_v;
logic clear;
logic win_done;
logic [`PCS_BAD_W-1:0] bad_cnt;
logic block_lock;

gearbox_if gb_if ();

// 64 to 66 regroup
gearbox_rx u_gearbox (
	.clk(clk),
	.nreset(nreset),
	.lock_v_i(lock_v_i),
	.data_i(data_i),
	.gb(gb_if.gbx)
);

// header window and bad count
sh_counter u_sh_counter (
	.clk(clk),
	.nreset(nreset),
	.count_v_i(cnt_v),
	.bad_v_i(bad_v),
	.clear_i(clear),
	.win_done_o(win_done),
	.bad_cnt_o(bad_cnt)
);

block_sync_fsm u_block_sync (
	.clk(clk),
	.nreset(nreset),
	.lock_v_i(lock_v_i),
	.gb(gb_if.sync),
	.win_done_i(win_done),
	.bad_cnt_i(bad_cnt),
	.cnt_v_o(cnt_v),
	.bad_v_o(bad_v),
	.clear_o(clear),
	.block_lock_o(block_lock)
);

// payload out one cycle after the block
descrambler u_descrambler (
	.clk(clk),
	.nreset(nreset),
	.blk_v_i(gb_if.blk_v),
	.block_lock_i(block_lock),
	.head_i(gb_if.head),
	.data_i(gb_if.data),
	.valid_o(valid_o),
	.head_o(head_o),
	.data_o(data_o)
);

assign block_lock_o = block_lock;

endmodule

// File: pcs_rx_tb.sv
`timescale 1ns/1ps
`include "pcs_cfg.svh"

module pcs_rx_tb import pcs_pkg::*; ();

localparam int HIST_W = `PCS_SCR_W;
localparam int EXT_W = HIST_W + `PCS_DATA_W;
// x^39 tap, seen from the start of the history
localparam int TAP = HIST_W - 39;
// lock bound of 66 x (window + 2) blocks, in cycles with the gap cycle
localparam int LOCK_WAIT = 66 * (`PCS_SYNC_WIN + 2) * 33 / 32 + 8;
localparam int CHECK_WAIT = 2000;

logic clk;
logic nreset;
logic lock_v;
logic [`PCS_DATA_W-1:0] data_in;
logic block_lock_o;
logic valid_o;
logic [`PCS_HEAD_W-1:0] head_o;
logic [`PCS_DATA_W-1:0] data_o;

logic [31:0] rng_state = 32'd13;
// serial bits still to send, oldest first
bit stream_q[$];
// last sent scrambled bits, oldest at bit 0
logic [HIST_W-1:0] tx_hist = '0;
logic [`PCS_BLOCK_W-1:0] exp_q[$];
int bad_left = 0;
logic hold_lock = 1'b0;
logic lock_d = 1'b0;
logic aligned = 1'b0;
int skip = 0;
int checked = 0;
int data_errs = 0;
int lock_errs = 0;
int timeout_errs = 0;

pcs_rx UUT (
	.clk(clk),
	.nreset(nreset),
	.lock_v_i(lock_v),
	.data_i(data_in),
	.block_lock_o(block_lock_o),
	.valid_o(valid_o),
	.head_o(head_o),
	.data_o(data_o)
);

initial begin
	clk = 1'b0;
	forever #4 clk = ~clk;
end

function automatic logic [31:0] next_rand();
	rng_state = rng_state * 32'd1664525 + 32'd1013904223;
	return rng_state;
endfunction

// tx scrambler, y = p ^ y(-39) ^ y(-58)
function automatic logic [`PCS_DATA_W-1:0] scramble(input logic [`PCS_DATA_W-1:0] pay,
		input logic [HIST_W-1:0] hist);
	logic [EXT_W-1:0] x;
	x = {{`PCS_DATA_W{1'b0}}, hist};
	for (int i = 0; i < `PCS_DATA_W; i++) begin
		x[HIST_W+i] = pay[i] ^ x[TAP+i] ^ x[i];
	end
	return x[EXT_W-1:HIST_W];
endfunction

// expected block, payload recovered from the scrambled bits on the wire
function automatic logic [`PCS_BLOCK_W-1:0] expected_block(input logic [`PCS_HEAD_W-1:0] head,
		input logic [`PCS_DATA_W-1:0] scr, input logic [HIST_W-1:0] hist);
	logic [EXT_W-1:0] x;
	logic [`PCS_DATA_W-1:0] pay;
	x = {scr, hist};
	for (int i = 0; i < `PCS_DATA_W; i++) begin
		pay[i] = x[HIST_W+i] ^ x[TAP+i] ^ x[i];
	end
	return {pay, head};
endfunction

// one random block onto the serial stream
task automatic make_block();
	logic [31:0] r;
	logic [`PCS_HEAD_W-1:0] head;
	logic [`PCS_DATA_W-1:0] pay;
	logic [`PCS_DATA_W-1:0] scr;
	logic [EXT_W-1:0] ext;
	logic [`PCS_BLOCK_W-1:0] blk;
	pay = {next_rand(), next_rand()};
	r = next_rand();
	head = r[31] ? SH_CTRL : SH_DATA;
	// injected bad header, 00 or 11
	if (bad_left > 0) begin
		head = r[30] ? 2'b11 : 2'b00;
		bad_left--;
	end
	scr = scramble(pay, tx_hist);
	exp_q.push_back(expected_block(head, scr, tx_hist));
	if (exp_q.size() > 256) begin
		void'(exp_q.pop_front());
	end
	ext = {scr, tx_hist};
	tx_hist = ext[EXT_W-1:`PCS_DATA_W];
	blk = {scr, head};
	for (int i = 0; i < `PCS_BLOCK_W; i++) begin
		stream_q.push_back(blk[i]);
	end
endtask

// serializer, bit 0 of each word goes first
always @(posedge clk) begin : drive
	logic [`PCS_DATA_W-1:0] w;
	while (stream_q.size() < `PCS_DATA_W) begin
		make_block();
	end
	for (int i = 0; i < `PCS_DATA_W; i++) begin
		w[i] = stream_q.pop_front();
	end
	data_in <= w;
end

always @(negedge clk) begin : check
	logic [`PCS_BLOCK_W-1:0] got;
	logic [`PCS_BLOCK_W-1:0] exp_blk;
	if (!nreset) begin
		lock_d = 1'b0;
	end else begin
		assert (!valid_o || lock_d) else begin
			$display("valid_o came out while block lock was low");
			lock_errs++;
		end
		if (hold_lock) begin
			assert (block_lock_o) else begin
				$display("FAIL block_lock_o got %h exp 1", block_lock_o);
				lock_errs++;
			end
		end
		if (valid_o) begin
			got = {data_o, head_o};
			if (skip < 2) begin
				// descrambler still filling
				skip++;
			end else if (!aligned) begin
				// find the output in the sent stream
				while (exp_q.size() > 0 && exp_q[0] != got) begin
					void'(exp_q.pop_front());
				end
				assert (exp_q.size() > 0) else begin
					$display("locked output matches no sent block");
					data_errs++;
				end
				if (exp_q.size() > 0) begin
					void'(exp_q.pop_front());
					aligned = 1'b1;
					checked++;
				end
			end else begin
				assert (exp_q.size() > 0) else begin
					$display("output block with no sent block left");
					data_errs++;
				end
				if (exp_q.size() > 0) begin
					exp_blk = exp_q.pop_front();
					assert (got[`PCS_HEAD_W-1:0] == exp_blk[`PCS_HEAD_W-1:0]) else begin
						$display("FAIL head_o got %h exp %h", got[`PCS_HEAD_W-1:0],
							exp_blk[`PCS_HEAD_W-1:0]);
						data_errs++;
					end
					assert (got[`PCS_BLOCK_W-1:`PCS_HEAD_W] == exp_blk[`PCS_BLOCK_W-1:`PCS_HEAD_W])
					else begin
						$display("FAIL data_o got %h exp %h", got[`PCS_BLOCK_W-1:`PCS_HEAD_W],
							exp_blk[`PCS_BLOCK_W-1:`PCS_HEAD_W]);
						data_errs++;
					end
					checked++;
				end
			end
		end
		// realign after every lock loss
		if (!block_lock_o) begin
			aligned = 1'b0;
			skip = 0;
		end
		lock_d = block_lock_o;
	end
end

task automatic wait_lock_level(input logic level);
	int n;
	n = 0;
	do begin
		@(negedge clk);
		n++;
	end while (block_lock_o !== level && n < LOCK_WAIT);
	assert (block_lock_o === level) else begin
		$display("block_lock_o did not reach %0d in time", level);
		timeout_errs++;
	end
endtask

// compared blocks are counted on the falling edge
task automatic wait_checked(input int blocks);
	int target;
	int n;
	target = checked + blocks;
	n = 0;
	do begin
		@(posedge clk);
		n++;
	end while (checked < target && n < CHECK_WAIT);
	assert (checked >= target) else begin
		$display("too few locked blocks compared in time");
		timeout_errs++;
	end
endtask

task automatic check_idle(input int cycles);
	repeat (cycles) begin
		@(negedge clk);
		assert (valid_o == 1'b0) else begin
			$display("FAIL valid_o got %h exp 0", valid_o);
			lock_errs++;
		end
		assert (block_lock_o == 1'b0) else begin
			$display("FAIL block_lock_o got %h exp 0", block_lock_o);
			lock_errs++;
		end
	end
endtask

initial begin : main
	int offset;
	logic [31:0] r;
	nreset = 1'b0;
	lock_v = 1'b0;
	data_in = '0;
	// random start offset, 0 to 65 bits of garbage
	offset = int'(next_rand() % 32'd66);
	for (int i = 0; i < offset; i++) begin
		r = next_rand();
		stream_q.push_back(r[31]);
	end
	repeat (10) @(posedge clk);
	nreset <= 1'b1;
	// nothing before pma lock
	check_idle(20);
	@(posedge clk);
	lock_v <= 1'b1;
	wait_lock_level(1'b1);
	wait_checked(100);
	// 15 bad headers fit in one window without a drop
	@(posedge clk);
	hold_lock = 1'b1;
	@(negedge clk);
	bad_left = 15;
	wait_checked(150);
	hold_lock = 1'b0;
	// 32 in a row put at least 16 in one window
	@(negedge clk);
	bad_left = 32;
	wait_lock_level(1'b0);
	wait_lock_level(1'b1);
	wait_checked(100);
	// pma loss and recovery
	@(posedge clk);
	lock_v <= 1'b0;
	wait_lock_level(1'b0);
	check_idle(8);
	@(posedge clk);
	lock_v <= 1'b1;
	wait_lock_level(1'b1);
	wait_checked(100);
	@(posedge clk);
	$display("errors: data %0d, lock %0d, timeout %0d; blocks compared %0d",
		data_errs, lock_errs, timeout_errs, checked);
	if (data_errs + lock_errs + timeout_errs == 0) begin
		$display("TESTS PASSED");
	end else begin
		$display("TESTS FAILED");
	end
	$finish;
end

endmodule

// File: pcs_rx.f
+incdir+.
pcs_pkg.sv
gearbox_if.sv
gearbox_rx.sv
sh_counter.sv
block_sync_fsm.sv
descrambler.sv
pcs_rx.sv
pcs_rx_tb.sv

// File: run.sh
#!/bin/bash
# build and run the pcs_rx testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f pcs_rx.f --top-module pcs_rx_tb -o pcs_rx_sim

./obj_dir/pcs_rx_sim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
